/* Makefile */
# Verilator build and run for the clock and uart subsystem

VERILATOR ?= verilator
TOP       ?= clk_uart_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* baud_tick_gen.sv */
// oversample and bit tick divider

`timescale 1ns/1ps

`include "uart_settings.svh"

module baud_tick_gen import clk_pkg::*; (
	input  logic out_sys_clk_x2,
	input  logic sys_reset,
	output logic os_tick,
	output logic bit_tick
);

	localparam os_count_t os_last = os_count_t'(`UART_OS_DIV - 1);
	localparam phase_t phase_last = phase_t'(`UART_OVERSAMPLE - 1);

	os_count_t os_count;
	phase_t phase;

	// --------------------
	// oversample divider
	// --------------------

	always_ff @(posedge out_sys_clk_x2 or posedge sys_reset) begin
		if (sys_reset) begin
			os_count <= '0;
			os_tick <= 1'b0;
		end else begin
			os_tick <= 1'b0;
			if (os_count == os_last) begin
				os_count <= '0;
				os_tick <= 1'b1;
			end else begin
				os_count <= os_count + 1'b1;
			end
		end
	end

	// phase within the bit, advanced per oversample tick
	always_ff @(posedge out_sys_clk_x2 or posedge sys_reset) begin
		if (sys_reset) begin
			phase <= '0;
		end else if (os_tick) begin
			phase <= (phase == phase_last) ? '0 : phase + 1'b1;
		end
	end

	// bit tick coincides with the last os tick of each bit
	assign bit_tick = os_tick && (phase == phase_last);

endmodule

/* clk_pkg.sv */
// clock and uart types

`include "uart_settings.svh"

package clk_pkg;

	// one data byte
	typedef logic [`UART_DATA_BITS-1:0] uart_data_t;

	// oversample divider counter
	typedef logic [$clog2(`UART_OS_DIV)-1:0] os_count_t;

	// oversample phase within one bit
	typedef logic [2:0] phase_t;

	// position within the data bits
	typedef logic [$clog2(`UART_DATA_BITS)-1:0] bit_index_t;

	typedef enum logic [2:0] {
		tx_st_idle,
		tx_st_start,
		tx_st_data,
		tx_st_stop,
		tx_st_wait_req_low
	} tx_state_t;

	typedef enum logic [2:0] {
		rx_st_idle,
		rx_st_start,
		rx_st_data,
		rx_st_stop,
		rx_st_handshake
	} rx_state_t;

endpackage

/* clk_uart_tb.sv */
// clock uart subsystem testbench

`timescale 1ns/1ps

`include "uart_settings.svh"

module clk_uart_tb import clk_pkg::*; ();

	localparam int bit_cycles = `UART_OS_DIV * `UART_OVERSAMPLE;
	localparam int frame_limit = 12 * bit_cycles;
	localparam int ack_limit = 16;
	localparam int num_stim = 6;
	localparam int num_lcg = 4;
	localparam int sel_tx_ack = 0;
	localparam int sel_rx_req = 1;

	typedef struct packed {
		uart_data_t send;
		logic       forced;
		logic       stop_bit;
		uart_data_t exp_data;
		logic       exp_err;
	} stim_t;

	logic out_sys_clk_x2;
	logic in_reset;
	logic dcm_locked;
	logic tx_req;
	uart_data_t tx_data;
	logic tx_ack;
	logic txd;
	logic rxd;
	logic rx_req;
	logic rx_ack;
	uart_data_t rx_data;
	logic rx_frame_err;
	logic sys_reset;

	logic rxd_drive;
	logic line_loop;
	uart_data_t exp_data;
	logic exp_err;
	logic stalled;
	logic [31:0] lcg_state;
	stim_t stim_table [num_stim];
	stim_t lcg_entry;
	int idx;

	// loopback routes txd straight back to the receiver
	assign rxd = line_loop ? txd : rxd_drive;

	tb_clock clock_gen (
		.out_sys_clk_x2 (out_sys_clk_x2)
	);

	clk_uart_top UUT (
		.out_sys_clk_x2 (out_sys_clk_x2),
		.in_reset       (in_reset),
		.dcm_locked     (dcm_locked),
		.tx_req         (tx_req),
		.tx_data        (tx_data),
		.tx_ack         (tx_ack),
		.txd            (txd),
		.rxd            (rxd),
		.rx_req         (rx_req),
		.rx_ack         (rx_ack),
		.rx_data        (rx_data),
		.rx_frame_err   (rx_frame_err),
		.sys_reset      (sys_reset)
	);

	uart_checker chk (
		.out_sys_clk_x2 (out_sys_clk_x2),
		.tx_req         (tx_req),
		.tx_data        (tx_data),
		.txd            (txd),
		.rx_req         (rx_req),
		.rx_data        (rx_data),
		.rx_frame_err   (rx_frame_err),
		.exp_data       (exp_data),
		.exp_err        (exp_err)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic watch(input int sel);
		case (sel)
			sel_rx_req: return rx_req;
			default: return tx_ack;
		endcase
	endfunction

	// --------------------
	// handshake helpers
	// --------------------

	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		while (watch(sel) !== level && n < limit) begin
			@(negedge out_sys_clk_x2);
			n++;
		end
		if (watch(sel) !== level) begin
			chk.note_failure(what);
			stalled = 1'b1;
		end
	endtask

	task automatic receive_byte();
		wait_level(sel_rx_req, 1'b1, frame_limit, "receive handshake stalled, rx_req never rose");
		if (stalled) begin
			return;
		end
		@(negedge out_sys_clk_x2);
		rx_ack = 1'b1;
		wait_level(sel_rx_req, 1'b0, ack_limit, "receive handshake stalled, rx_req stayed high");
		if (stalled) begin
			return;
		end
		@(negedge out_sys_clk_x2);
		rx_ack = 1'b0;
	endtask

	task automatic send_loopback(input uart_data_t value);
		@(negedge out_sys_clk_x2);
		line_loop = 1'b1;
		tx_data = value;
		tx_req = 1'b1;
		receive_byte();
		if (stalled) begin
			return;
		end
		wait_level(sel_tx_ack, 1'b1, frame_limit, "transmit handshake stalled, tx_ack never rose");
		if (stalled) begin
			return;
		end
		@(negedge out_sys_clk_x2);
		tx_req = 1'b0;
		wait_level(sel_tx_ack, 1'b0, ack_limit, "transmit handshake stalled, tx_ack stayed high");
	endtask

	task automatic drive_bit(input logic level);
		@(negedge out_sys_clk_x2);
		rxd_drive = level;
		repeat (bit_cycles - 1) @(negedge out_sys_clk_x2);
	endtask

	// start bit, data LSB first, then the chosen stop level
	task automatic send_forced(input uart_data_t value, input logic stop_bit);
		int i;
		line_loop = 1'b0;
		drive_bit(1'b0);
		for (i = 0; i < `UART_DATA_BITS; i++) begin
			drive_bit(value[i]);
		end
		drive_bit(stop_bit);
		@(negedge out_sys_clk_x2);
		rxd_drive = 1'b1;
		receive_byte();
	endtask

	task automatic run_entry(input stim_t entry, input string name);
		@(negedge out_sys_clk_x2);
		exp_data = entry.exp_data;
		exp_err = entry.exp_err;
		if (entry.forced) begin
			send_forced(entry.send, entry.stop_bit);
		end else begin
			send_loopback(entry.send);
		end
		chk.close_test(name);
	endtask

	// --------------------
	// reset and line tests
	// --------------------

	task automatic check_reset_release();
		int k;
		repeat (16) begin
			@(negedge out_sys_clk_x2);
			chk.compare_bit("sys_reset", sys_reset, 1'b1);
		end
		in_reset = 1'b0;
		for (k = 1; k <= `RESET_STRETCH; k++) begin
			@(negedge out_sys_clk_x2);
			chk.compare_bit("sys_reset", sys_reset, k < `RESET_STRETCH);
		end
		chk.close_test("reset release");
	endtask

	task automatic check_idle();
		@(negedge out_sys_clk_x2);
		chk.compare_bit("txd", txd, 1'b1);
		chk.compare_bit("tx_ack", tx_ack, 1'b0);
		chk.compare_bit("rx_req", rx_req, 1'b0);
		chk.compare_bit("rx_frame_err", rx_frame_err, 1'b0);
		chk.close_test("idle after reset");
	endtask

	task automatic check_false_start();
		int n;
		logic seen;
		seen = 1'b0;
		@(negedge out_sys_clk_x2);
		line_loop = 1'b0;
		rxd_drive = 1'b0;
		repeat (bit_cycles / 4) @(negedge out_sys_clk_x2);
		rxd_drive = 1'b1;
		for (n = 0; n < 10 * bit_cycles; n++) begin
			@(negedge out_sys_clk_x2);
			seen = seen | rx_req;
		end
		chk.compare_bit("rx_req", seen, 1'b0);
		chk.close_test("false start");
	endtask

	task automatic check_lock_loss();
		int k;
		@(negedge out_sys_clk_x2);
		dcm_locked = 1'b0;
		@(negedge out_sys_clk_x2);
		chk.compare_bit("sys_reset", sys_reset, 1'b1);
		dcm_locked = 1'b1;
		for (k = 1; k <= `RESET_STRETCH; k++) begin
			@(negedge out_sys_clk_x2);
			chk.compare_bit("sys_reset", sys_reset, k < `RESET_STRETCH);
		end
		chk.close_test("lock loss");
	endtask

	initial begin
		in_reset = 1'b1;
		dcm_locked = 1'b1;
		tx_req = 1'b0;
		tx_data = '0;
		rx_ack = 1'b0;
		rxd_drive = 1'b1;
		line_loop = 1'b1;
		exp_data = '0;
		exp_err = 1'b0;
		stalled = 1'b0;
		lcg_state = 32'd26650;

		// send, forced, stop bit, expected byte, expected frame error
		stim_table[0] = '{8'h55, 1'b0, 1'b1, 8'h55, 1'b0};
		stim_table[1] = '{8'ha3, 1'b0, 1'b1, 8'ha3, 1'b0};
		stim_table[2] = '{8'h00, 1'b0, 1'b1, 8'h00, 1'b0};
		stim_table[3] = '{8'hff, 1'b0, 1'b1, 8'hff, 1'b0};
		stim_table[4] = '{8'h3c, 1'b1, 1'b0, 8'h3c, 1'b1};
		stim_table[5] = '{8'hc5, 1'b1, 1'b1, 8'hc5, 1'b0};

		check_reset_release();
		check_idle();
		for (idx = 0; idx < num_stim && !stalled; idx++) begin
			run_entry(stim_table[idx], $sformatf("frame %0d byte %h %s", idx,
				stim_table[idx].send, stim_table[idx].forced ? "forced" : "loopback"));
		end
		for (idx = 0; idx < num_lcg && !stalled; idx++) begin
			lcg_state = lcg_next(lcg_state);
			lcg_entry = '{lcg_state[23:16], 1'b0, 1'b1, lcg_state[23:16], 1'b0};
			run_entry(lcg_entry, $sformatf("random frame %0d byte %h", idx, lcg_entry.send));
		end
		if (!stalled) begin
			check_false_start();
		end
		if (!stalled) begin
			check_lock_loss();
		end

		$display("summary: %0d passed, %0d failed", chk.pass_count, chk.fail_count);
		if (chk.fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* clk_uart_top.sv */
// clock, reset and uart top

`timescale 1ns/1ps

module clk_uart_top import clk_pkg::*; (
	input  logic       out_sys_clk_x2,
	input  logic       in_reset,
	input  logic       dcm_locked,
	input  logic       tx_req,
	input  uart_data_t tx_data,
	output logic       tx_ack,
	output logic       txd,
	input  logic       rxd,
	output logic       rx_req,
	input  logic       rx_ack,
	output uart_data_t rx_data,
	output logic       rx_frame_err,
	output logic       sys_reset
);

	logic os_tick;
	logic bit_tick;

	// --------------------
	// clock and reset
	// --------------------

	reset_sequencer u_reset_sequencer (
		.in_reset       (in_reset),
		.out_sys_clk_x2 (out_sys_clk_x2),
		.dcm_locked     (dcm_locked),
		.sys_reset      (sys_reset)
	);

	baud_tick_gen u_baud_tick_gen (
		.out_sys_clk_x2 (out_sys_clk_x2),
		.sys_reset      (sys_reset),
		.os_tick        (os_tick),
		.bit_tick       (bit_tick)
	);

	// --------------------
	// serial port
	// --------------------

	uart_tx u_uart_tx (
		.out_sys_clk_x2 (out_sys_clk_x2),
		.sys_reset      (sys_reset),
		.bit_tick       (bit_tick),
		.tx_req         (tx_req),
		.tx_data        (tx_data),
		.tx_ack         (tx_ack),
		.txd            (txd)
	);

	uart_rx u_uart_rx (
		.out_sys_clk_x2 (out_sys_clk_x2),
		.sys_reset      (sys_reset),
		.os_tick        (os_tick),
		.rxd            (rxd),
		.rx_ack         (rx_ack),
		.rx_req         (rx_req),
		.rx_data        (rx_data),
		.rx_frame_err   (rx_frame_err)
	);

endmodule

/* reset_sequencer.sv */
// system reset sequencer

`timescale 1ns/1ps

`include "uart_settings.svh"

module reset_sequencer (
	input  logic in_reset,
	input  logic out_sys_clk_x2,
	input  logic dcm_locked,
	output logic sys_reset
);

	// ones loaded on reset or lock loss, zeros shifted in once locked
	logic [`RESET_STRETCH-1:0] reset_shift;

	always_ff @(posedge out_sys_clk_x2 or posedge in_reset) begin
		if (in_reset) begin
			reset_shift <= '1;
		end else if (!dcm_locked) begin
			reset_shift <= '1;
		end else begin
			reset_shift <= reset_shift >> 1;
		end
	end

	// last stage drives the system reset
	assign sys_reset = reset_shift[0];

	// --------------------
	// checks
	// --------------------

	// losing lock must put the system back into reset on the next edge
	a_lock_loss_reset: assert property (
		@(posedge out_sys_clk_x2) !dcm_locked |=> sys_reset
	) else $error("sys_reset not raised after lock loss");

endmodule

/* src.f */
+incdir+.
clk_pkg.sv
reset_sequencer.sv
baud_tick_gen.sv
uart_tx.sv
uart_rx.sv
clk_uart_top.sv
tb_clock.sv
uart_checker.sv
clk_uart_tb.sv

/* tb_clock.sv */
// testbench clock source

`timescale 1ns/1ps

module tb_clock #(
	parameter int half_period_ns = 50
) (
	output logic out_sys_clk_x2
);

	initial out_sys_clk_x2 = 1'b0;

	// 100 ns period
	always #(half_period_ns) out_sys_clk_x2 = ~out_sys_clk_x2;

endmodule

/* uart_checker.sv */
// uart response checker

`timescale 1ns/1ps

`include "uart_settings.svh"

module uart_checker import clk_pkg::*; (
	input logic       out_sys_clk_x2,
	input logic       tx_req,
	input uart_data_t tx_data,
	input logic       txd,
	input logic       rx_req,
	input uart_data_t rx_data,
	input logic       rx_frame_err,
	input uart_data_t exp_data,
	input logic       exp_err
);

	localparam int bit_cycles = `UART_OS_DIV * `UART_OVERSAMPLE;

	int pass_count = 0;
	int fail_count = 0;
	int test_errors = 0;
	int low_len = 0;
	logic rx_req_q = 1'b0;
	logic tx_req_q = 1'b0;
	logic txd_q = 1'b1;
	logic armed = 1'b0;
	logic measuring = 1'b0;
	uart_data_t frame_data = '0;

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_byte(input string name, input uart_data_t got, input uart_data_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%0t: %s", $time, msg);
		test_errors++;
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0) begin
			$display("[PASS] %s", name);
			pass_count++;
		end else begin
			$display("[FAIL] %s, %0d errors", name, test_errors);
			fail_count++;
		end
		test_errors = 0;
	endtask

	// low run starts with the start bit and spans any leading zero data bits
	task automatic check_low_run();
		int bits;
		int i;
		int expected;
		int diff;
		bits = 1;
		i = 0;
		while (i < `UART_DATA_BITS && !frame_data[i]) begin
			bits++;
			i++;
		end
		expected = bits * bit_cycles;
		diff = low_len - expected;
		if (diff < 0) begin
			diff = -diff;
		end
		if (diff > `UART_OS_DIV) begin
			$display("ERR %0t txd_start_bit got %0d cycles expected %0d", $time, low_len,
				expected);
			test_errors++;
		end
	endtask

	// --------------------
	// monitor
	// --------------------

	always @(negedge out_sys_clk_x2) begin
		if (rx_req && !rx_req_q) begin
			compare_byte("rx_data", rx_data, exp_data);
			compare_bit("rx_frame_err", rx_frame_err, exp_err);
		end
		if (tx_req && !tx_req_q) begin
			frame_data = tx_data;
			armed = 1'b1;
		end
		if (measuring) begin
			if (txd) begin
				measuring = 1'b0;
				check_low_run();
			end else begin
				low_len++;
			end
		end else if (armed && txd_q && !txd) begin
			armed = 1'b0;
			measuring = 1'b1;
			low_len = 1;
		end
		rx_req_q = rx_req;
		tx_req_q = tx_req;
		txd_q = txd;
	end

endmodule

/* uart_rx.sv */
// oversampling uart receiver

`timescale 1ns/1ps

`include "uart_settings.svh"

module uart_rx import clk_pkg::*; (
	input  logic       out_sys_clk_x2,
	input  logic       sys_reset,
	input  logic       os_tick,
	input  logic       rxd,
	input  logic       rx_ack,
	output logic       rx_req,
	output uart_data_t rx_data,
	output logic       rx_frame_err
);

	localparam bit_index_t last_bit = bit_index_t'(`UART_DATA_BITS - 1);
	localparam phase_t mid_phase = phase_t'(`UART_OVERSAMPLE / 2);
	localparam phase_t phase_last = phase_t'(`UART_OVERSAMPLE - 1);

	rx_state_t  state;
	phase_t     phase;
	bit_index_t bit_idx;
	uart_data_t rx_shift;
	// two sync stages plus one history stage
	logic [2:0] rxd_pipe;
	logic       rxd_sync;
	logic       start_edge;
	logic       sample;

	assign rxd_sync = rxd_pipe[1];
	assign start_edge = rxd_pipe[2] && !rxd_sync;
	assign sample = os_tick && (phase == mid_phase);

	always_ff @(posedge out_sys_clk_x2 or posedge sys_reset) begin
		if (sys_reset) begin
			rxd_pipe <= '1;
		end else begin
			rxd_pipe <= {rxd_pipe[1:0], rxd};
		end
	end

	// --------------------
	// frame state machine
	// --------------------

	always_ff @(posedge out_sys_clk_x2 or posedge sys_reset) begin
		if (sys_reset) begin
			state <= rx_st_idle;
			phase <= '0;
			bit_idx <= '0;
			rx_req <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			// phase keeps running modulo one bit while in a frame
			if (os_tick && state != rx_st_idle && state != rx_st_handshake) begin
				phase <= (phase == phase_last) ? '0 : phase + 1'b1;
			end
			case (state)
				rx_st_idle: begin
					if (start_edge) begin
						phase <= '0;
						state <= rx_st_start;
					end
				end
				rx_st_start: begin
					// line back high at mid start bit is a glitch
					if (sample) begin
						bit_idx <= '0;
						state <= rxd_sync ? rx_st_idle : rx_st_data;
					end
				end
				rx_st_data: begin
					if (sample) begin
						if (bit_idx == last_bit) begin
							state <= rx_st_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				rx_st_stop: begin
					if (sample) begin
						rx_frame_err <= !rxd_sync;
						rx_req <= 1'b1;
						state <= rx_st_handshake;
					end
				end
				rx_st_handshake: begin
					// frames arriving here are dropped
					if (rx_req && rx_ack) begin
						rx_req <= 1'b0;
					end else if (!rx_req && !rx_ack) begin
						state <= rx_st_idle;
					end
				end
				default: state <= rx_st_idle;
			endcase
		end
	end

	// data shifter and output byte
	always_ff @(posedge out_sys_clk_x2) begin
		if (state == rx_st_data && sample) begin
			rx_shift <= {rxd_sync, rx_shift[`UART_DATA_BITS-1:1]};
		end
		if (state == rx_st_stop && sample) begin
			rx_data <= rx_shift;
		end
	end

	a_data_stable: assert property (
		@(posedge out_sys_clk_x2) disable iff (sys_reset)
		rx_req |=> !rx_req || $stable(rx_data)
	) else $error("rx_data changed during open handshake");

endmodule

/* uart_settings.svh */
// uart and reset settings

`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// --------------------
// baud generation
// --------------------

// clock cycles per oversample tick, 8 x 115200 bps
`define UART_OS_DIV 108

// oversample ticks per bit
`define UART_OVERSAMPLE 8

// --------------------
// frame and reset
// --------------------

`define UART_DATA_BITS 8

// cycles of reset kept after lock
`define RESET_STRETCH 2

`endif

/* uart_tx.sv */
// uart transmitter

`timescale 1ns/1ps

`include "uart_settings.svh"

module uart_tx import clk_pkg::*; (
	input  logic       out_sys_clk_x2,
	input  logic       sys_reset,
	input  logic       bit_tick,
	input  logic       tx_req,
	input  uart_data_t tx_data,
	output logic       tx_ack,
	output logic       txd
);

	localparam bit_index_t last_bit = bit_index_t'(`UART_DATA_BITS - 1);

	tx_state_t  state;
	bit_index_t bit_idx;
	uart_data_t tx_shift;

	// --------------------
	// frame state machine
	// --------------------

	always_ff @(posedge out_sys_clk_x2 or posedge sys_reset) begin
		if (sys_reset) begin
			state <= tx_st_idle;
			bit_idx <= '0;
			tx_ack <= 1'b0;
			txd <= 1'b1;
		end else begin
			case (state)
				tx_st_idle: begin
					// start bit goes out on the first bit tick with req up
					if (tx_req && bit_tick) begin
						txd <= 1'b0;
						state <= tx_st_start;
					end
				end
				tx_st_start: begin
					if (bit_tick) begin
						txd <= tx_shift[0];
						bit_idx <= '0;
						state <= tx_st_data;
					end
				end
				tx_st_data: begin
					if (bit_tick) begin
						if (bit_idx == last_bit) begin
							txd <= 1'b1;
							state <= tx_st_stop;
						end else begin
							txd <= tx_shift[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				tx_st_stop: begin
					// end of stop bit; a withdrawn request gets no ack
					if (bit_tick) begin
						tx_ack <= tx_req;
						state <= tx_req ? tx_st_wait_req_low : tx_st_idle;
					end
				end
				tx_st_wait_req_low: begin
					if (!tx_req) begin
						tx_ack <= 1'b0;
						state <= tx_st_idle;
					end
				end
				default: state <= tx_st_idle;
			endcase
		end
	end

	// byte shifter, LSB first
	always_ff @(posedge out_sys_clk_x2) begin
		if (state == tx_st_idle && tx_req && bit_tick) begin
			tx_shift <= tx_data;
		end else if ((state == tx_st_start || state == tx_st_data) && bit_tick) begin
			tx_shift <= tx_shift >> 1;
		end
	end

	a_ack_needs_req: assert property (
		@(posedge out_sys_clk_x2) disable iff (sys_reset)
		$rose(tx_ack) |-> tx_req
	) else $error("tx_ack rose without tx_req");

endmodule
